// File: common/fetch_pkg.sv
package fetch_pkg;

  // ========================================
  // datapath widths
  // ========================================
  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] WORD_BYTES = 32'd4;  // pc step

  // ========================================
  // cache geometry
  // ========================================
  localparam int NUM_SETS   = 4;
  localparam int IDX_W      = 2;
  localparam int OFF_W      = 1;
  localparam int TAG_W      = XLEN - IDX_W - OFF_W - 2;
  localparam int LINE_BYTES = 8;

  // pc field positions
  localparam int OFF_LSB = 2;                  // word in line
  localparam int IDX_LSB = OFF_LSB + OFF_W;    // set index
  localparam int TAG_LSB = IDX_LSB + IDX_W;

  // ========================================
  // reset vector
  // ========================================
  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  // ========================================
  // opcodes that end a fetch run
  // ========================================
  localparam int OP_W = 7;

  localparam logic [OP_W-1:0] OP_JAL    = 7'b1101111;
  localparam logic [OP_W-1:0] OP_JALR   = 7'b1100111;
  localparam logic [OP_W-1:0] OP_BRANCH = 7'b1100011;
  localparam logic [OP_W-1:0] OP_SYSTEM = 7'b1110011;  // ecall, ebreak, csr, mret

  // fence.i as one exact word with rd = rs1 = 0 and imm = 0
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100F;

endpackage

// File: icache/icache_set.sv
`timescale 1ns/1ps

module icache_set #(
  parameter int SET_ID = 0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [fetch_pkg::XLEN-1:0]  lookup_pc_i,
  input  logic                        fill_en_i,
  input  logic [fetch_pkg::OFF_W-1:0] fill_word_i,
  input  logic [fetch_pkg::XLEN-1:0]  fill_data_i,
  input  logic                        inv_all_i,
  output logic                        hit_o,
  output logic [fetch_pkg::XLEN-1:0]  word_o
);

  logic                        valid_q;
  logic [fetch_pkg::TAG_W-1:0] tag_q;
  logic [fetch_pkg::XLEN-1:0]  data_q [2**fetch_pkg::OFF_W];

  logic [fetch_pkg::IDX_W-1:0] pc_idx;
  logic [fetch_pkg::OFF_W-1:0] pc_off;
  logic [fetch_pkg::TAG_W-1:0] pc_tag;
  logic                        selected;
  logic                        fill_here;

  assign pc_idx = lookup_pc_i[fetch_pkg::IDX_LSB +: fetch_pkg::IDX_W];
  assign pc_off = lookup_pc_i[fetch_pkg::OFF_LSB +: fetch_pkg::OFF_W];
  assign pc_tag = lookup_pc_i[fetch_pkg::TAG_LSB +: fetch_pkg::TAG_W];

  assign selected  = (int'(pc_idx) == SET_ID);
  assign fill_here = selected && fill_en_i;

  // read side
  assign hit_o  = selected && valid_q && (tag_q == pc_tag);
  assign word_o = data_q[pc_off];

  always_ff @(posedge clk)
  begin
    if (rst || inv_all_i)
      valid_q <= 1'b0;
    else if (fill_here)
      valid_q <= (fill_word_i == 1'b1);  // word 0 opens the line, word 1 closes it
  end

  always_ff @(posedge clk)
  begin
    if (fill_here)
    begin
      data_q[fill_word_i] <= fill_data_i;
      tag_q               <= pc_tag;
    end
  end

endmodule

// File: icache/icache_select.sv
`timescale 1ns/1ps

module icache_select (
  input  logic [fetch_pkg::NUM_SETS-1:0]                      set_hit_i,
  input  logic [fetch_pkg::NUM_SETS-1:0][fetch_pkg::XLEN-1:0] set_word_i,
  output logic                                                hit_o,
  output logic [fetch_pkg::XLEN-1:0]                          inst_o,
  output logic                                                is_ctrl_flow_o,
  output logic                                                is_fence_o
);

  logic [fetch_pkg::OP_W-1:0] opcode;

  // ========================================
  // hit merge
  // ========================================
  assign hit_o = |set_hit_i;

  // at most one set hits
  always_comb
  begin
    inst_o = '0;
    for (int i = 0; i < fetch_pkg::NUM_SETS; i++)
    begin
      if (set_hit_i[i])
        inst_o = inst_o | set_word_i[i];
    end
  end

  // ========================================
  // predecode
  // ========================================
  assign opcode = inst_o[fetch_pkg::OP_W-1:0];

  always_comb
  begin
    case (opcode)
      fetch_pkg::OP_JAL,
      fetch_pkg::OP_JALR,
      fetch_pkg::OP_BRANCH,
      fetch_pkg::OP_SYSTEM:
        is_ctrl_flow_o = 1'b1;
      default:
        is_ctrl_flow_o = 1'b0;
    endcase
  end

  assign is_fence_o = (inst_o == fetch_pkg::INST_FENCE_I);  // full word match

endmodule

// File: source/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  // bus read
  output logic                        rd_valid_o,
  input  logic                        rd_ready_i,
  output logic [fetch_pkg::XLEN-1:0]  rd_addr_o,
  input  logic                        rdata_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]  rdata_i,
  // cache side
  output logic [fetch_pkg::XLEN-1:0]  lookup_pc_o,
  input  logic                        hit_i,
  input  logic                        is_ctrl_flow_i,
  input  logic                        is_fence_i,
  output logic                        fill_en_o,
  output logic [fetch_pkg::OFF_W-1:0] fill_word_o,
  output logic [fetch_pkg::XLEN-1:0]  fill_data_o,
  output logic                        inv_all_o,
  // back end
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  input  logic                        redirect_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]  redirect_pc_i
);

  typedef enum logic [2:0] {
    LOOKUP,
    REQ0,
    WAIT0,
    REQ1,
    WAIT1,
    HOLD
  } state_e;

  state_e                      state_q;
  state_e                      state_d;
  logic [fetch_pkg::XLEN-1:0]  pc_q;
  logic [fetch_pkg::XLEN-1:0]  pc_d;
  logic [fetch_pkg::XLEN-1:0]  line_base;
  logic                        accept;

  // ========================================
  // lookup and delivery
  // ========================================
  assign lookup_pc_o = pc_q;
  assign out_valid_o = (state_q == LOOKUP) && hit_i;
  assign accept      = out_valid_o && out_ready_i;
  assign inv_all_o   = accept && is_fence_i;  // valid bits drop on next edge

  assign line_base = {pc_q[fetch_pkg::XLEN-1:$clog2(fetch_pkg::LINE_BYTES)],
                      {$clog2(fetch_pkg::LINE_BYTES){1'b0}}};

  assign fill_data_o = rdata_i;

  // ========================================
  // next state
  // ========================================
  always_comb
  begin
    state_d     = state_q;
    pc_d        = pc_q;
    rd_valid_o  = 1'b0;
    rd_addr_o   = line_base;
    fill_en_o   = 1'b0;
    fill_word_o = '0;
    case (state_q)
      LOOKUP:
      begin
        if (accept)
        begin
          if (is_ctrl_flow_i)
            state_d = HOLD;  // park until redirect
          else
            pc_d = pc_q + fetch_pkg::WORD_BYTES;
        end
        else if (!hit_i)
        begin
          state_d = REQ0;
        end
      end
      REQ0:
      begin
        rd_valid_o = 1'b1;
        if (rd_ready_i)
          state_d = WAIT0;
      end
      WAIT0:
      begin
        fill_en_o = rdata_valid_i;  // word 0 beat
        if (rdata_valid_i)
          state_d = REQ1;
      end
      REQ1:
      begin
        rd_valid_o = 1'b1;
        rd_addr_o  = line_base + fetch_pkg::WORD_BYTES;
        if (rd_ready_i)
          state_d = WAIT1;
      end
      WAIT1:
      begin
        fill_en_o   = rdata_valid_i;
        fill_word_o = 1'b1;  // second beat completes the line
        if (rdata_valid_i)
          state_d = LOOKUP;
      end
      HOLD:
      begin
        if (redirect_valid_i)
        begin
          pc_d    = redirect_pc_i;
          state_d = LOOKUP;
        end
      end
      default:
      begin
        state_d = LOOKUP;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= LOOKUP;
      pc_q    <= fetch_pkg::RESET_PC;
    end
    else
    begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst,
  // bus read
  output logic                       rd_valid_o,
  input  logic                       rd_ready_i,
  output logic [fetch_pkg::XLEN-1:0] rd_addr_o,
  input  logic                       rdata_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  // instruction out
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic [fetch_pkg::XLEN-1:0] out_pc_o,
  output logic [fetch_pkg::XLEN-1:0] out_inst_o,
  // redirect from back end
  input  logic                       redirect_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i
);

  logic [fetch_pkg::XLEN-1:0]                          lookup_pc;
  logic                                                fill_en;
  logic [fetch_pkg::OFF_W-1:0]                         fill_word;
  logic [fetch_pkg::XLEN-1:0]                          fill_data;
  logic                                                inv_all;
  logic [fetch_pkg::NUM_SETS-1:0]                      set_hit;
  logic [fetch_pkg::NUM_SETS-1:0][fetch_pkg::XLEN-1:0] set_word;
  logic                                                hit;
  logic                                                is_ctrl_flow;
  logic                                                is_fence;

  fetch_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .rd_valid_o       (rd_valid_o),
    .rd_ready_i       (rd_ready_i),
    .rd_addr_o        (rd_addr_o),
    .rdata_valid_i    (rdata_valid_i),
    .rdata_i          (rdata_i),
    .lookup_pc_o      (lookup_pc),
    .hit_i            (hit),
    .is_ctrl_flow_i   (is_ctrl_flow),
    .is_fence_i       (is_fence),
    .fill_en_o        (fill_en),
    .fill_word_o      (fill_word),
    .fill_data_o      (fill_data),
    .inv_all_o        (inv_all),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i)
  );

  // ========================================
  // cache sets
  // ========================================
  for (genvar i = 0; i < fetch_pkg::NUM_SETS; i++)
  begin : g_set
    icache_set #(
      .SET_ID (i)
    ) u_set (
      .clk         (clk),
      .rst         (rst),
      .lookup_pc_i (lookup_pc),
      .fill_en_i   (fill_en),
      .fill_word_i (fill_word),
      .fill_data_i (fill_data),
      .inv_all_i   (inv_all),
      .hit_o       (set_hit[i]),
      .word_o      (set_word[i])
    );
  end

  icache_select u_select (
    .set_hit_i      (set_hit),
    .set_word_i     (set_word),
    .hit_o          (hit),
    .inst_o         (out_inst_o),
    .is_ctrl_flow_o (is_ctrl_flow),
    .is_fence_o     (is_fence)
  );

  assign out_pc_o = lookup_pc;  // pc of the word being looked up

endmodule

// File: testbench/fetch_unit_assertions.sv
`timescale 1ns/1ps

module fetch_unit_assertions (
  input logic        clk,
  input logic        rst,
  input logic        rd_valid_i,
  input logic        rd_ready_i,
  input logic [31:0] rd_addr_i,
  input logic        rdata_valid_i,
  input logic        out_valid_i,
  input logic        out_ready_i,
  input logic [31:0] out_pc_i,
  input logic [31:0] out_inst_i
);

  logic read_open;  // address taken, data still out

  always_ff @(posedge clk)
  begin
    if (rst)
      read_open <= 1'b0;
    else if (rd_valid_i && rd_ready_i)
      read_open <= 1'b1;
    else if (rdata_valid_i)
      read_open <= 1'b0;
  end

  // ========================================
  // bus read
  // ========================================
  addr_stable: assert property (@(posedge clk) disable iff (rst)
    rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_addr_i))
    else $error("read address changed while the read waited");

  one_outstanding: assert property (@(posedge clk) disable iff (rst)
    read_open |-> !rd_valid_i)
    else $error("second read address issued before data returned");

  // ========================================
  // instruction out
  // ========================================
  out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_pc_i) && $stable(out_inst_i))
    else $error("instruction output changed while stalled");

  reset_quiet: assert property (@(posedge clk)
    rst |=> !out_valid_i && !rd_valid_i)
    else $error("valid raised during reset");

endmodule

// File: testbench/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

  localparam int          HALF_PERIOD    = 50;
  localparam int          RESET_CYCLES   = 10;
  localparam int          NUM_INSTS      = 400;
  localparam int          ACCEPT_TIMEOUT = 200;
  localparam int          WINDOW_WORDS   = 64;
  localparam logic [31:0] WINDOW_BYTES   = 32'd256;
  localparam logic [31:0] SEED           = 32'd84;

  logic        clk = 1'b0;
  logic        rst;
  logic        rd_valid;
  logic        rd_ready;
  logic [31:0] rd_addr;
  logic        rdata_valid;
  logic [31:0] rdata;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] out_pc;
  logic [31:0] out_inst;
  logic        redirect_valid;
  logic [31:0] redirect_pc;

  // models
  logic [31:0] rng_state;
  logic [31:0] mem [WINDOW_WORDS];
  logic        model_valid [4];
  logic [26:0] model_tag [4];
  logic [31:0] read_q [$];

  logic        bus_pending;
  int          bus_countdown;
  logic [31:0] bus_addr;
  logic        redirect_due;
  int          redirect_delay;
  logic        wait_redirect;
  logic [31:0] exp_pc;
  logic        stalled_last;
  logic [31:0] stall_pc;
  logic [31:0] stall_inst;
  logic        accepted_now;
  logic        timed_out;

  int errors;
  int accepted;
  int misses;
  int fences;
  int redirects;

  always #(HALF_PERIOD) clk = ~clk;

  fetch_unit dut (
    .clk              (clk),
    .rst              (rst),
    .rd_valid_o       (rd_valid),
    .rd_ready_i       (rd_ready),
    .rd_addr_o        (rd_addr),
    .rdata_valid_i    (rdata_valid),
    .rdata_i          (rdata),
    .out_valid_o      (out_valid),
    .out_ready_i      (out_ready),
    .out_pc_o         (out_pc),
    .out_inst_o       (out_inst),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc)
  );

  bind fetch_unit fetch_unit_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .rd_valid_i    (rd_valid_o),
    .rd_ready_i    (rd_ready_i),
    .rd_addr_i     (rd_addr_o),
    .rdata_valid_i (rdata_valid_i),
    .out_valid_i   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_pc_i      (out_pc_o),
    .out_inst_i    (out_inst_o)
  );

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [6:0] pick_opcode(input logic ctrl, input logic [1:0] sel);
    logic [6:0] ctrl_ops [4];
    logic [6:0] plain_ops [4];
    ctrl_ops  = '{7'b1101111, 7'b1100111, 7'b1100011, 7'b1110011};
    plain_ops = '{7'b0010011, 7'b0110011, 7'b0000011, 7'b0100011};
    return ctrl ? ctrl_ops[sel] : plain_ops[sel];
  endfunction

  function automatic logic is_ctrl_word(input logic [31:0] inst);
    case (inst[6:0])
      7'b1101111, 7'b1100111, 7'b1100011, 7'b1110011: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // window contents, or a pattern of the whole address outside it
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] offs;
    offs = addr - fetch_pkg::RESET_PC;
    if (offs < WINDOW_BYTES)
      return mem[offs[7:2]];
    return {addr[31:7] ^ addr[24:0], 7'b0010011};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic fill_memory();
    logic [31:0] kind;
    logic [31:0] body;
    for (int i = 0; i < WINDOW_WORDS; i++)
    begin
      kind = next_random();
      body = next_random();
      if (kind[3:0] < 4'd3)
        mem[6'(i)] = {body[31:7], pick_opcode(1'b1, body[1:0])};
      else if (kind[3:0] == 4'd3)
        mem[6'(i)] = fetch_pkg::INST_FENCE_I;
      else
        mem[6'(i)] = {body[31:7], pick_opcode(1'b0, body[1:0])};
    end
  endtask

  // ========================================
  // per cycle sampling and driving
  // ========================================
  task automatic check_accept(input logic [31:0] pc, input logic [31:0] inst);
    logic [31:0] want;
    logic [1:0]  idx;
    logic [31:0] base;
    want = mem_word(pc);
    idx  = pc[4:3];
    base = {pc[31:3], 3'b000};
    check_value("pc sequence", exp_pc, pc);
    check_value("instruction", want, inst);
    if (model_valid[idx] && model_tag[idx] == pc[31:5])
    begin
      check_value("reads on hit", 32'd0, 32'(read_q.size()));
    end
    else
    begin
      misses++;
      check_value("reads on miss", 32'd2, 32'(read_q.size()));
      if (read_q.size() == 2)
      begin
        check_value("refill addr 0", base, read_q[0]);
        check_value("refill addr 1", base + 32'd4, read_q[1]);
      end
      model_valid[idx] = 1'b1;
      model_tag[idx]   = pc[31:5];
    end
    read_q.delete();
    accepted++;
    if (want == fetch_pkg::INST_FENCE_I)
    begin
      fences++;
      for (int s = 0; s < 4; s++)
        model_valid[2'(s)] = 1'b0;  // whole cache dropped
      exp_pc = pc + 32'd4;
    end
    else if (is_ctrl_word(want))
    begin
      wait_redirect  = 1'b1;
      redirect_due   = 1'b1;
      redirect_delay = int'(next_random() & 32'd3);
    end
    else
    begin
      exp_pc = pc + 32'd4;
    end
  endtask

  task automatic sample_outputs();
    if (stalled_last)
    begin
      if (!out_valid)
      begin
        errors++;
        $display("out_valid dropped while the back end held it off");
      end
      check_value("stall pc", stall_pc, out_pc);
      check_value("stall inst", stall_inst, out_inst);
    end
    stalled_last = out_valid && !out_ready;
    stall_pc     = out_pc;
    stall_inst   = out_inst;
    if (wait_redirect && out_valid)
    begin
      errors++;
      $display("instruction at %h delivered before the redirect", out_pc);
    end
    if (redirect_valid)
      wait_redirect = 1'b0;
    if (rd_valid && rd_ready)
    begin
      read_q.push_back(rd_addr);
      bus_pending   = 1'b1;
      bus_addr      = rd_addr;
      bus_countdown = int'(next_random() & 32'd3);  // 1 to 4 cycles
    end
    if (out_valid && out_ready)
    begin
      accepted_now = 1'b1;
      check_accept(out_pc, out_inst);
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r           = next_random();
    rd_ready    = r[4];
    out_ready   = (r[9:8] != 2'b00);
    rdata_valid = 1'b0;
    rdata       = 32'd0;
    if (bus_pending)
    begin
      if (bus_countdown == 0)
      begin
        rdata_valid = 1'b1;
        rdata       = mem_word(bus_addr);
        bus_pending = 1'b0;
      end
      else
        bus_countdown--;
    end
    redirect_valid = 1'b0;
    if (redirect_due)
    begin
      if (redirect_delay == 0)
      begin
        redirect_valid = 1'b1;
        redirect_pc    = fetch_pkg::RESET_PC + {24'd0, r[21:16], 2'b00};
        exp_pc         = redirect_pc;
        redirect_due   = 1'b0;
        redirects++;
      end
      else
        redirect_delay--;
    end
  endtask

  task automatic step_cycle();
    accepted_now = 1'b0;
    @(negedge clk);
    sample_outputs();
    @(posedge clk);
    #1;
    drive_inputs();
  endtask

  task automatic wait_for_accept();
    int cycles;
    cycles       = 0;
    accepted_now = 1'b0;
    while (!accepted_now && cycles < ACCEPT_TIMEOUT)
    begin
      step_cycle();
      cycles++;
    end
    if (!accepted_now)
    begin
      errors++;
      timed_out = 1'b1;
      $display("no instruction delivered within timeout, expected pc %h", exp_pc);
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial
  begin
    rst            = 1'b1;
    rd_ready       = 1'b0;
    rdata_valid    = 1'b0;
    rdata          = 32'd0;
    out_ready      = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = 32'd0;
    rng_state      = SEED;
    bus_pending    = 1'b0;
    bus_countdown  = 0;
    bus_addr       = 32'd0;
    redirect_due   = 1'b0;
    redirect_delay = 0;
    wait_redirect  = 1'b0;
    exp_pc         = fetch_pkg::RESET_PC;
    stalled_last   = 1'b0;
    stall_pc       = 32'd0;
    stall_inst     = 32'd0;
    accepted_now   = 1'b0;
    timed_out      = 1'b0;
    errors         = 0;
    accepted       = 0;
    misses         = 0;
    fences         = 0;
    redirects      = 0;
    for (int s = 0; s < 4; s++)
    begin
      model_valid[2'(s)] = 1'b0;
      model_tag[2'(s)]   = 27'd0;
    end
    fill_memory();

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    while (accepted < NUM_INSTS && !timed_out)
      wait_for_accept();

    $display("accepted %0d misses %0d fences %0d redirects %0d errors %0d",
             accepted, misses, fences, redirects, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: fetch_unit.f
common/fetch_pkg.sv
icache/icache_set.sv
icache/icache_select.sv
source/fetch_ctrl.sv
source/fetch_unit.sv
testbench/fetch_unit_assertions.sv
testbench/fetch_unit_tb.sv

// File: Makefile
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$($(abspath $(BIN)))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
